// File: risc8_cfg.svh
/*
 * risc8 configuration macros
 * datapath widths, register count, status flag positions and start address
 */
`ifndef RISC8_CFG_SVH
`define RISC8_CFG_SVH

// data byte and address widths
`define RISC8_DATA_W 8
`define RISC8_ADDR_W 16

// general purpose registers r0..r31
`define RISC8_NREGS 32

// status register bit positions, AVR order
`define RISC8_SREG_C 0
`define RISC8_SREG_Z 1
`define RISC8_SREG_N 2
`define RISC8_SREG_V 3
`define RISC8_SREG_S 4
`define RISC8_SREG_H 5

// first fetch address after reset
`define RISC8_RESET_PC 16'h0000

`endif

// File: risc8_pkg.sv
/*
 * risc8 shared types
 * opcode, ALU operation, status register and request structs
 */
`include "risc8_cfg.svh"

package risc8_pkg;

	// one program memory word
	typedef logic [15:0] opcode_t;

	// register index r0..r31
	typedef logic [4:0] reg_sel_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_MOVR,
		ALU_NEG,
		ALU_SWAP,
		ALU_ASR,
		ALU_LSR,
		ALU_ROR
	} alu_op_e;

	// field order matches the RISC8_SREG_* bit positions
	typedef struct packed {
		logic i;
		logic t;
		logic h;
		logic s;
		logic v;
		logic n;
		logic z;
		logic c;
	} sreg_t;

	typedef enum logic [2:0] {
		INSN_ALU,
		INSN_BRANCH,
		INSN_RJMP,
		INSN_LDS,
		INSN_STS,
		INSN_NOP
	} insn_class_e;

	// one ALU instruction on its way from stage 1 to stage 2
	typedef struct packed {
		alu_op_e op;
		logic use_carry;
		logic use_const;
		logic [`RISC8_DATA_W-1:0] const_value;
		logic store;
		reg_sel_t dest;
		logic keep_flags;
	} alu_req_t;

	// single cycle data memory strobe
	typedef struct packed {
		logic [`RISC8_ADDR_W-1:0] addr;
		logic [`RISC8_DATA_W-1:0] wdata;
		logic wen;
		logic ren;
	} mem_req_t;

endpackage

// File: risc8_decoder.sv
/*
 * risc8 instruction decoder
 * classifies the opcode word, builds the ALU request and the read selects
 */
`timescale 1ns/1ps

module risc8_decoder import risc8_pkg::*; (
	input opcode_t opcode,
	input logic [1:0] cycle,
	output insn_class_e insn_class,
	output alu_req_t alu_req,
	output reg_sel_t sel_a,
	output reg_sel_t sel_b
);
	reg_sel_t op_rd;
	reg_sel_t op_rr;
	reg_sel_t op_rdi;
	logic [7:0] op_k;
	logic imm_form;

	// operand fields
	assign op_rd = opcode[8:4];
	assign op_rr = {opcode[9], opcode[3:0]};
	// immediate forms only reach r16..r31
	assign op_rdi = {1'b1, opcode[7:4]};
	assign op_k = {opcode[11:8], opcode[3:0]};

	// cpi, sbci, subi, ori, andi and ldi share the Rdi/K layout
	assign imm_form = (opcode[15:12] >= 4'h3 && opcode[15:12] <= 4'h7)
		|| opcode[15:12] == 4'he;

	function automatic alu_req_t make_req(input alu_op_e op, input logic carry,
			input logic use_k, input logic [7:0] k, input logic store,
			input logic keep, input reg_sel_t dest);
		alu_req_t r;
		r.op = op;
		r.use_carry = carry;
		r.use_const = use_k;
		r.const_value = k;
		r.store = store;
		r.dest = dest;
		r.keep_flags = keep;
		return r;
	endfunction

	always_comb begin
		insn_class = INSN_NOP;
		sel_a = op_rd;
		sel_b = op_rr;
		// no write and no flag update
		alu_req = make_req(ALU_MOVR, 1'b0, 1'b0, 8'h00, 1'b0, 1'b1, op_rd);

		// Rd bits opcode[8:4] are a wildcard for nearly everything
		casez ({opcode[15:9], opcode[3:0]})
		// register-register forms
		11'b0000_01?_????: alu_req = make_req(ALU_SUB, 1'b1, 1'b0, 8'h00, 1'b0, 1'b0, op_rd);
		11'b0000_10?_????: alu_req = make_req(ALU_SUB, 1'b1, 1'b0, 8'h00, 1'b1, 1'b0, op_rd);
		11'b0000_11?_????: alu_req = make_req(ALU_ADD, 1'b0, 1'b0, 8'h00, 1'b1, 1'b0, op_rd);
		11'b0001_01?_????: alu_req = make_req(ALU_SUB, 1'b0, 1'b0, 8'h00, 1'b0, 1'b0, op_rd);
		11'b0001_10?_????: alu_req = make_req(ALU_SUB, 1'b0, 1'b0, 8'h00, 1'b1, 1'b0, op_rd);
		11'b0001_11?_????: alu_req = make_req(ALU_ADD, 1'b1, 1'b0, 8'h00, 1'b1, 1'b0, op_rd);
		11'b0010_00?_????: alu_req = make_req(ALU_AND, 1'b0, 1'b0, 8'h00, 1'b1, 1'b0, op_rd);
		11'b0010_01?_????: alu_req = make_req(ALU_EOR, 1'b0, 1'b0, 8'h00, 1'b1, 1'b0, op_rd);
		11'b0010_10?_????: alu_req = make_req(ALU_OR, 1'b0, 1'b0, 8'h00, 1'b1, 1'b0, op_rd);
		11'b0010_11?_????: alu_req = make_req(ALU_MOVR, 1'b0, 1'b0, 8'h00, 1'b1, 1'b1, op_rd);
		// register-immediate forms cpi sbci subi ori andi ldi
		11'b0011_???_????: alu_req = make_req(ALU_SUB, 1'b0, 1'b1, op_k, 1'b0, 1'b0, op_rdi);
		11'b0100_???_????: alu_req = make_req(ALU_SUB, 1'b1, 1'b1, op_k, 1'b1, 1'b0, op_rdi);
		11'b0101_???_????: alu_req = make_req(ALU_SUB, 1'b0, 1'b1, op_k, 1'b1, 1'b0, op_rdi);
		11'b0110_???_????: alu_req = make_req(ALU_OR, 1'b0, 1'b1, op_k, 1'b1, 1'b0, op_rdi);
		11'b0111_???_????: alu_req = make_req(ALU_AND, 1'b0, 1'b1, op_k, 1'b1, 1'b0, op_rdi);
		11'b1110_???_????: alu_req = make_req(ALU_MOVR, 1'b0, 1'b1, op_k, 1'b1, 1'b1, op_rdi);
		// single register forms
		// com is eor with ff and inc / dec use a constant 1
		11'b1001_010_0000: alu_req = make_req(ALU_EOR, 1'b0, 1'b1, 8'hff, 1'b1, 1'b0, op_rd);
		11'b1001_010_0001: alu_req = make_req(ALU_NEG, 1'b0, 1'b0, 8'h00, 1'b1, 1'b0, op_rd);
		11'b1001_010_0010: alu_req = make_req(ALU_SWAP, 1'b0, 1'b0, 8'h00, 1'b1, 1'b1, op_rd);
		11'b1001_010_0011: alu_req = make_req(ALU_ADD, 1'b0, 1'b1, 8'h01, 1'b1, 1'b0, op_rd);
		11'b1001_010_0101: alu_req = make_req(ALU_ASR, 1'b0, 1'b0, 8'h00, 1'b1, 1'b0, op_rd);
		11'b1001_010_0110: alu_req = make_req(ALU_LSR, 1'b0, 1'b0, 8'h00, 1'b1, 1'b0, op_rd);
		11'b1001_010_0111: alu_req = make_req(ALU_ROR, 1'b0, 1'b0, 8'h00, 1'b1, 1'b0, op_rd);
		11'b1001_010_1010: alu_req = make_req(ALU_SUB, 1'b0, 1'b1, 8'h01, 1'b1, 1'b0, op_rd);
		// lds writes Rd only in its last cycle with the byte from memory
		11'b1001_000_0000: begin
			insn_class = INSN_LDS;
			if (cycle == 2'd2)
				alu_req = make_req(ALU_MOVR, 1'b0, 1'b1, 8'h00, 1'b1, 1'b1, op_rd);
		end
		// sts passes Rd through the ALU on port b
		11'b1001_001_0000: begin
			insn_class = INSN_STS;
			sel_b = op_rd;
		end
		11'b1100_???_????: insn_class = INSN_RJMP;
		11'b1111_0??_????: insn_class = INSN_BRANCH;
		default: ;
		endcase

		if (imm_form)
			sel_a = op_rdi;
		// anything that writes a register or the flags is an ALU op
		if (insn_class == INSN_NOP && (alu_req.store || !alu_req.keep_flags))
			insn_class = INSN_ALU;
	end

endmodule

// File: risc8_control.sv
/*
 * risc8 control
 * program counter, lds/sts sequencing, branch resolution,
 * stage 2 request register and status register
 */
`timescale 1ns/1ps
`include "risc8_cfg.svh"

module risc8_control import risc8_pkg::*; (
	input logic clk,
	input logic reset,
	input opcode_t cdata,
	input logic [`RISC8_DATA_W-1:0] data_read,
	input insn_class_e insn_class,
	input alu_req_t alu_req,
	input logic [`RISC8_DATA_W-1:0] alu_result,
	input sreg_t alu_sreg,
	output opcode_t opcode,
	output logic [1:0] cycle,
	output logic [`RISC8_ADDR_W-1:0] pc,
	output mem_req_t mem_req,
	output alu_req_t stage2_req,
	output sreg_t sreg,
	output logic wr_en,
	output reg_sel_t wr_sel,
	output logic [`RISC8_DATA_W-1:0] wr_data
);
	localparam alu_req_t IDLE_REQ = '{op: ALU_MOVR, use_carry: 1'b0, use_const: 1'b0,
		const_value: 8'h00, store: 1'b0, dest: 5'd0, keep_flags: 1'b1};

	logic [`RISC8_ADDR_W-1:0] reg_pc;
	logic [`RISC8_ADDR_W-1:0] next_pc;
	logic [1:0] next_cycle;
	logic force_pc;
	opcode_t prev_opcode;
	// low for one cycle after reset while the first word is fetched
	logic running;
	insn_class_e cls;
	alu_req_t s1_req;
	sreg_t next_sreg;
	logic [7:0] flag_bits;
	logic [`RISC8_ADDR_W-1:0] simm7;
	logic [`RISC8_ADDR_W-1:0] simm12;
	logic br_taken;

	// later cycles of lds / sts re-use the first opcode word
	assign opcode = (cycle == 2'd0) ? cdata : prev_opcode;

	// the program memory fetches the next PC directly
	assign pc = next_pc;

	// branches see the flags of the op still in stage 2
	assign next_sreg = stage2_req.keep_flags ? sreg : alu_sreg;
	assign flag_bits = next_sreg;
	// brbs has opcode[10] clear and brbc has it set
	assign br_taken = flag_bits[opcode[2:0]] == !opcode[10];

	assign simm7 = {{9{opcode[9]}}, opcode[9:3]};
	assign simm12 = {{4{opcode[11]}}, opcode[11:0]};

	assign cls = running ? insn_class : INSN_NOP;

	always_comb begin
		next_pc = reg_pc + 16'd1;
		next_cycle = 2'd0;
		force_pc = 1'b0;
		mem_req = '0;
		s1_req = running ? alu_req : IDLE_REQ;

		case (cls)
		INSN_BRANCH: begin
			if (br_taken)
				next_pc = reg_pc + simm7 + 16'd1;
		end
		INSN_RJMP: next_pc = reg_pc + simm12 + 16'd1;
		INSN_STS: begin
			if (cycle == 2'd0) begin
				// step onto the address word
				force_pc = 1'b1;
				next_cycle = 2'd1;
			end else begin
				// cdata is the address and the ALU passes Rd through
				mem_req.addr = cdata;
				mem_req.wdata = alu_result;
				mem_req.wen = 1'b1;
			end
		end
		INSN_LDS: begin
			case (cycle)
			2'd0: begin
				force_pc = 1'b1;
				next_cycle = 2'd1;
			end
			2'd1: begin
				// hold the PC while next_pc already fetches the following op
				mem_req.addr = cdata;
				mem_req.ren = 1'b1;
				next_cycle = 2'd2;
			end
			default: s1_req.const_value = data_read;
			endcase
		end
		default: begin
			// stall the fetch until the first word is in
			if (!running)
				next_pc = reg_pc;
		end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_pc <= `RISC8_RESET_PC;
			cycle <= 2'd0;
			running <= 1'b0;
			stage2_req <= IDLE_REQ;
			sreg <= '0;
		end else begin
			running <= 1'b1;
			cycle <= next_cycle;
			if (force_pc || next_cycle == 2'd0)
				reg_pc <= next_pc;
			prev_opcode <= opcode;
			stage2_req <= s1_req;
			sreg <= next_sreg;
		end
	end

	// stage 2 write port
	assign wr_en = stage2_req.store;
	assign wr_sel = stage2_req.dest;
	assign wr_data = alu_result;

	// quiet through reset and the fetch cycle after it
	a_reset_quiet: assert property (@(posedge clk)
		reset |-> !(mem_req.wen || mem_req.ren) ##1 !(mem_req.wen || mem_req.ren));

endmodule

// File: risc8_regfile.sv
/*
 * risc8 register file
 * 32 x 8 flops, two registered read ports with write-through bypass
 */
`timescale 1ns/1ps
`include "risc8_cfg.svh"

module risc8_regfile import risc8_pkg::*; (
	input logic clk,
	input logic reset,
	input reg_sel_t sel_a,
	input reg_sel_t sel_b,
	input logic wr_en,
	input reg_sel_t wr_sel,
	input logic [`RISC8_DATA_W-1:0] wr_data,
	output logic [`RISC8_DATA_W-1:0] rd_a,
	output logic [`RISC8_DATA_W-1:0] rd_b
);
	logic [`RISC8_DATA_W-1:0] regs [`RISC8_NREGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `RISC8_NREGS; i++)
				regs[i] <= '0;
			rd_a <= '0;
			rd_b <= '0;
		end else begin
			if (wr_en)
				regs[wr_sel] <= wr_data;
			// a write in the same cycle wins over the stored value
			if (wr_en && wr_sel == sel_a)
				rd_a <= wr_data;
			else
				rd_a <= regs[sel_a];
			if (wr_en && wr_sel == sel_b)
				rd_b <= wr_data;
			else
				rd_b <= regs[sel_b];
		end
	end

endmodule

// File: risc8_alu.sv
/*
 * risc8 ALU
 * 8-bit result and next status register, AVR flag rules
 */
`timescale 1ns/1ps
`include "risc8_cfg.svh"

module risc8_alu import risc8_pkg::*; (
	input alu_req_t req,
	input logic [`RISC8_DATA_W-1:0] rd_a,
	input logic [`RISC8_DATA_W-1:0] rd_b,
	input sreg_t sreg_in,
	output logic [`RISC8_DATA_W-1:0] result,
	output sreg_t sreg_out
);
	logic [7:0] opb;
	logic cin;
	// neg is 0 - Rd on the subtractor
	logic [7:0] sub_x;
	logic [7:0] sub_y;
	logic [8:0] wide;
	logic [4:0] nib;
	logic [7:0] f;

	assign opb = req.use_const ? req.const_value : rd_b;
	assign cin = req.use_carry & sreg_in.c;
	assign sub_x = (req.op == ALU_NEG) ? 8'h00 : rd_a;
	assign sub_y = (req.op == ALU_NEG) ? rd_a : opb;

	always_comb begin
		f = sreg_in;
		wide = '0;
		nib = '0;
		result = opb;

		case (req.op)
		ALU_ADD: begin
			wide = {1'b0, rd_a} + {1'b0, opb} + {8'd0, cin};
			nib = {1'b0, rd_a[3:0]} + {1'b0, opb[3:0]} + {4'd0, cin};
			result = wide[7:0];
			f[`RISC8_SREG_C] = wide[8];
			f[`RISC8_SREG_H] = nib[4];
			f[`RISC8_SREG_V] = (rd_a[7] == opb[7]) && (result[7] != rd_a[7]);
		end
		ALU_SUB, ALU_NEG: begin
			// bit 8 and bit 4 come out as the borrows
			wide = {1'b0, sub_x} - {1'b0, sub_y} - {8'd0, cin};
			nib = {1'b0, sub_x[3:0]} - {1'b0, sub_y[3:0]} - {4'd0, cin};
			result = wide[7:0];
			f[`RISC8_SREG_C] = wide[8];
			f[`RISC8_SREG_H] = nib[4];
			f[`RISC8_SREG_V] = (sub_x[7] != sub_y[7]) && (result[7] != sub_x[7]);
		end
		ALU_AND: result = rd_a & opb;
		ALU_OR: result = rd_a | opb;
		ALU_EOR: result = rd_a ^ opb;
		ALU_SWAP: result = {rd_a[3:0], rd_a[7:4]};
		ALU_ASR: result = {rd_a[7], rd_a[7:1]};
		ALU_LSR: result = {1'b0, rd_a[7:1]};
		ALU_ROR: result = {sreg_in.c, rd_a[7:1]};
		default: ;
		endcase

		// logic ops clear V
		if (req.op == ALU_AND || req.op == ALU_OR || req.op == ALU_EOR)
			f[`RISC8_SREG_V] = 1'b0;
		// shifts move bit 0 into C, V is N xor C
		if (req.op == ALU_ASR || req.op == ALU_LSR || req.op == ALU_ROR) begin
			f[`RISC8_SREG_C] = rd_a[0];
			f[`RISC8_SREG_V] = result[7] ^ rd_a[0];
		end

		f[`RISC8_SREG_N] = result[7];
		// sbc / cpc only keep Z set across a zero byte
		if (req.op == ALU_SUB && req.use_carry)
			f[`RISC8_SREG_Z] = (result == 8'h00) && sreg_in.z;
		else
			f[`RISC8_SREG_Z] = (result == 8'h00);
		f[`RISC8_SREG_S] = f[`RISC8_SREG_N] ^ f[`RISC8_SREG_V];

		sreg_out = f;
	end

endmodule

// File: risc8_core.sv
/*
 * risc8 core top level
 * two stage AVR subset, control plus decoder, register file and ALU
 */
`timescale 1ns/1ps
`include "risc8_cfg.svh"

module risc8_core import risc8_pkg::*; (
	input logic clk,
	input logic reset,
	// synchronous program ROM, word at pc returns on the next clock
	output logic [`RISC8_ADDR_W-1:0] pc,
	input logic [15:0] cdata,
	// data memory, single cycle strobes
	output logic [`RISC8_ADDR_W-1:0] data_addr,
	output logic data_wen,
	output logic data_ren,
	input logic [`RISC8_DATA_W-1:0] data_read,
	output logic [`RISC8_DATA_W-1:0] data_write
);
	opcode_t opcode;
	logic [1:0] cycle;
	insn_class_e insn_class;
	alu_req_t alu_req;
	alu_req_t stage2_req;
	reg_sel_t sel_a;
	reg_sel_t sel_b;
	logic [`RISC8_DATA_W-1:0] rd_a;
	logic [`RISC8_DATA_W-1:0] rd_b;
	logic [`RISC8_DATA_W-1:0] alu_result;
	sreg_t alu_sreg;
	sreg_t sreg;
	mem_req_t mem_req;
	logic wr_en;
	reg_sel_t wr_sel;
	logic [`RISC8_DATA_W-1:0] wr_data;

	risc8_control control_i (
		.clk(clk),
		.reset(reset),
		.cdata(cdata),
		.data_read(data_read),
		.insn_class(insn_class),
		.alu_req(alu_req),
		.alu_result(alu_result),
		.alu_sreg(alu_sreg),
		.opcode(opcode),
		.cycle(cycle),
		.pc(pc),
		.mem_req(mem_req),
		.stage2_req(stage2_req),
		.sreg(sreg),
		.wr_en(wr_en),
		.wr_sel(wr_sel),
		.wr_data(wr_data)
	);

	risc8_decoder decoder_i (
		.opcode(opcode),
		.cycle(cycle),
		.insn_class(insn_class),
		.alu_req(alu_req),
		.sel_a(sel_a),
		.sel_b(sel_b)
	);

	risc8_regfile regfile_i (
		.clk(clk),
		.reset(reset),
		.sel_a(sel_a),
		.sel_b(sel_b),
		.wr_en(wr_en),
		.wr_sel(wr_sel),
		.wr_data(wr_data),
		.rd_a(rd_a),
		.rd_b(rd_b)
	);

	// stage 2 operates on operands read for the registered request
	risc8_alu alu_i (
		.req(stage2_req),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.sreg_in(sreg),
		.result(alu_result),
		.sreg_out(alu_sreg)
	);

	assign data_addr = mem_req.addr;
	assign data_wen = mem_req.wen;
	assign data_ren = mem_req.ren;
	assign data_write = mem_req.wdata;

endmodule

// File: risc8_tb.sv
/*
 * risc8 core testbench
 * program ROM and data memory models, table driven store checks, watchdog
 */
`timescale 1ns/1ps
`include "risc8_cfg.svh"

module risc8_tb;

	localparam int RESET_CYCLES = 16;
	localparam int DRAIN_CYCLES = 20;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic [15:0] pc;
	logic [15:0] cdata = 16'h0000;
	logic [15:0] data_addr;
	logic data_wen;
	logic data_ren;
	logic [7:0] data_read = 8'h00;
	logic [7:0] data_write;

	logic [15:0] tdata [0:1023];
	logic [15:0] rom [0:255];
	logic [7:0] dmem [0:65535];
	// every data write, in order
	int wr_addr_log [$];
	int wr_byte_log [$];
	int seed = 37261;
	int limit_cycles = 0;

	logic [15:0] fetch_word;
	logic [7:0] read_byte;
	logic read_q;

	risc8_core dut_i (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.cdata(cdata),
		.data_addr(data_addr),
		.data_wen(data_wen),
		.data_ren(data_ren),
		.data_read(data_read),
		.data_write(data_write)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	// sync ROM and data memory, sampled on the edge, answered 1 ns later
	always @(posedge clk) begin
		fetch_word = rom[pc[7:0]];
		read_byte = dmem[data_addr];
		read_q = data_ren;
		if (data_wen) begin
			wr_addr_log.push_back(int'(data_addr));
			wr_byte_log.push_back(int'(data_write));
		end
		#1;
		cdata = fetch_word;
		if (read_q)
			data_read = read_byte;
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("watchdog: the core stopped making progress after %0d cycles", limit_cycles);
		$display("CHECKS FAILED");
		$fatal(1, "timeout");
	end

	function automatic int word_at(input int p);
		return int'(tdata[p[9:0]]);
	endfunction

	function automatic string test_name(input int idx);
		case (idx)
		0: return "alu_reg";
		1: return "flags_branch";
		2: return "rjmp";
		3: return "lds_sts";
		default: return "unknown";
		endcase
	endfunction

	task automatic check_value(input string what, input int expected, input int actual);
		if (expected != actual) begin
			$display("Mismatch %s: expected %0h actual %0h", what, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	initial begin
		int pos;
		int ntests;
		int total_words;
		int name_idx;
		int nwords;
		int npre;
		int nexp;
		int idx;
		int log_base;
		int rnd;
		int addr;
		int val;
		logic [7:0] last_rand;
		logic [7:0] want_byte;
		int exp_addr [$];
		int exp_byte [$];
		string tname;

		last_rand = 8'h00;
		$readmemh("risc8_testdata.txt", tdata);
		ntests = word_at(0);
		if (ntests <= 0 || ntests > 16) begin
			$display("the test data file is missing or holds no tests");
			$display("CHECKS FAILED");
			$fatal(1, "no test data");
		end

		// walk the sections once to size the watchdog
		pos = 1;
		total_words = 0;
		for (int t = 0; t < ntests; t++) begin
			nwords = word_at(pos + 1);
			total_words += nwords;
			pos += 2 + nwords;
			npre = word_at(pos);
			pos += 1 + 2 * npre;
			nexp = word_at(pos);
			pos += 1 + 2 * nexp;
		end
		limit_cycles = total_words * 3 + 100 * ntests;

		pos = 1;
		for (int t = 0; t < ntests; t++) begin
			name_idx = word_at(pos);
			tname = test_name(name_idx);
			nwords = word_at(pos + 1);
			pos += 2;

			// hold the core in reset while the memories are reloaded
			@(posedge clk);
			#1;
			reset = 1'b1;
			// low page words decode as NOP
			for (int a = 0; a < 256; a++)
				rom[a[7:0]] = {8'h00, a[7:0]};
			for (int i = 0; i < nwords; i++)
				rom[i[7:0]] = 16'(word_at(pos + i));
			pos += nwords;
			for (int a = 0; a < 65536; a++)
				dmem[a[15:0]] = a[7:0] ^ a[15:8] ^ 8'h5a;

			npre = word_at(pos);
			pos++;
			for (int i = 0; i < npre; i++) begin
				addr = word_at(pos);
				val = word_at(pos + 1);
				pos += 2;
				if (val[8]) begin
					rnd = $random(seed);
					last_rand = rnd[7:0];
					dmem[addr[15:0]] = last_rand;
				end else begin
					dmem[addr[15:0]] = val[7:0];
				end
			end

			nexp = word_at(pos);
			pos++;
			exp_addr.delete();
			exp_byte.delete();
			for (int i = 0; i < nexp; i++) begin
				addr = word_at(pos);
				val = word_at(pos + 1);
				pos += 2;
				// flagged entries expect the random byte minus K
				want_byte = val[8] ? last_rand - val[7:0] : val[7:0];
				exp_addr.push_back(addr);
				exp_byte.push_back(int'(want_byte));
			end
			log_base = wr_addr_log.size();

			repeat (RESET_CYCLES) begin
				@(negedge clk);
				check_value({tname, " data_wen in reset"}, 0, int'(data_wen));
				check_value({tname, " data_ren in reset"}, 0, int'(data_ren));
				@(posedge clk);
			end
			#1;
			reset = 1'b0;
			@(negedge clk);
			check_value({tname, " first pc"}, int'(`RISC8_RESET_PC), int'(pc));
			check_value({tname, " data_wen after reset"}, 0, int'(data_wen));
			check_value({tname, " data_ren after reset"}, 0, int'(data_ren));

			// compare each store as it shows up
			idx = 0;
			while (idx < nexp) begin
				@(negedge clk);
				while (idx < nexp && log_base + idx < wr_addr_log.size()) begin
					check_value($sformatf("%s store %0d addr", tname, idx),
						exp_addr[idx], wr_addr_log[log_base + idx]);
					check_value($sformatf("%s store %0d byte", tname, idx),
						exp_byte[idx], wr_byte_log[log_base + idx]);
					idx++;
				end
			end
			// the program now spins on its last rjmp, no more stores allowed
			repeat (DRAIN_CYCLES) @(negedge clk);
			check_value({tname, " store count"}, nexp, wr_addr_log.size() - log_base);
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: risc8_testdata.txt
// hex words: test count, then per test name index, program length, program words,
// preload count, preload addr/byte pairs, store count, expected addr/byte pairs
// a byte with bit 8 set means a random preload, or that random byte minus the low 8 bits
0004
// alu_reg: ldi, add, adc, sub, sbc, logic ops, mov and single register ops
0000 0022
EF00 E215 0F01 1F11 9300 0100 9310 0101
1B01 0B10 9300 0102 9310 0103 E32C 2320
2B21 2720 2F32 9530 9330 0104 9531 9532
9533 9330 0105 9536 9537 9535 953A 9330
0106 CFFF
0000
0007 0100 0015 0101 004B 0102 00CA 0103 0080
0104 00BD 0105 0035 0106 00C5
// flags_branch: cp, cpc, cpi then brbs / brbc pick the marker byte
0001 002A
EA4A E555 E100 E210 E820 E131
1701 F018 9350 0200 C002 9340 0200
0730 F019 9350 0201 C002 9340 0201
3100 F41A 9350 0202 C002 9340 0202
3021 F01B 9350 0203 C002 9340 0203
3200 F418 9350 0204 C002 9340 0204
CFFF
0000
0005 0200 00AA 0201 0055 0202 00AA 0203 00AA 0204 0055
// rjmp: stores to 0300 and 0302 are jumped over
0002 000D
E101 E212 C002 9300 0300 9310 0301 C002 9300 0302 9300 0303 CFFF
0000
0002 0301 0022 0303 0011
// lds_sts: random byte minus 37, then a fixed byte copied through
0003 000A
9100 0400 5307 9300 0401 9110 0410 9310 0411 CFFF
0002 0400 0100 0410 009C
0002 0401 0137 0411 009C

// File: filelist.f
+incdir+.
risc8_pkg.sv
risc8_decoder.sv
risc8_control.sv
risc8_regfile.sv
risc8_alu.sv
risc8_core.sv
risc8_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := risc8_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
